/* rtl/insn_decode_settings.svh */
`ifndef INSN_DECODE_SETTINGS_SVH
`define INSN_DECODE_SETTINGS_SVH

// number of byte slots in the fetch queue
`define FIFO_DEPTH 16

// width of the queue read and write pointers, log2 of the depth
`define FIFO_ADDR_BITS 4

`endif

/* rtl/insn_decode_pkg.sv */
`default_nettype none

package insn_decode_pkg;

    // repeat prefix carried with a string instruction
    typedef enum logic [1:0] {
        REP_PREFIX_NONE,
        REP_PREFIX_E,
        REP_PREFIX_NE
    } rep_prefix_t;

    // segment registers in the order of the override prefix encoding
    typedef enum logic [1:0] {
        ES,
        CS,
        SS,
        DS
    } sr_t;

    // an immediate or displacement, filled a byte at a time and read as one word
    typedef union packed {
        logic [15:0] value;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } imm_word_t;

    // one fully decoded instruction as handed to the consumer
    typedef struct packed {
        logic [7:0] opcode;
        logic has_modrm;
        logic [7:0] mod_rm;
        logic [15:0] displacement;
        imm_word_t [1:0] immediates;
        logic lock;
        rep_prefix_t rep;
        logic has_segment_override;
        sr_t segment;
        logic [7:0] length;
    } instruction_t;

endpackage

`default_nettype wire

/* rtl/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "insn_decode_settings.svh"

module byte_fifo (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic wr_en,
    input logic [7:0] wr_data,
    input logic rd_en,
    output logic [7:0] rd_data,
    output logic empty,
    output logic full
);

    logic [7:0] mem [`FIFO_DEPTH];
    logic [`FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [`FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [`FIFO_ADDR_BITS:0] count;
    logic do_wr;
    logic do_rd;

    // writes into a full queue and reads from an empty one are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty = count == '0;
    assign full = count == (`FIFO_ADDR_BITS+1)'(`FIFO_DEPTH);

    // the head byte is always visible so the decoder can look before it pops
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* rtl/opcode_table.sv */
`timescale 1ns/1ps
`default_nettype none

module opcode_table (
    input logic [7:0] opcode,
    input logic [2:0] modrm_reg,
    output logic has_modrm,
    output logic [1:0] immed_count,
    output logic first_is_8bit,
    output logic second_is_8bit
);

    always_comb begin
        has_modrm = 1'b0;
        immed_count = 2'd0;
        first_is_8bit = 1'b0;
        second_is_8bit = 1'b0;

        if (opcode[7:6] == 2'b00) begin
            // arithmetic block, the low three bits pick the operand form
            case (opcode[2:0])
                3'd0, 3'd1, 3'd2, 3'd3: has_modrm = 1'b1;
                3'd4: begin
                    immed_count = 2'd1;
                    first_is_8bit = 1'b1;
                end
                3'd5: immed_count = 2'd1;
                default: ;
            endcase
        end else begin
            casez (opcode)
                8'h80, 8'h83: begin
                    has_modrm = 1'b1;
                    immed_count = 2'd1;
                    first_is_8bit = 1'b1;
                end
                8'h81: begin
                    has_modrm = 1'b1;
                    immed_count = 2'd1;
                end
                // mov r/m forms, shifts and the inc/dec group
                8'b1000_10??, 8'b1101_00??, 8'hfe, 8'hff: has_modrm = 1'b1;
                8'b1011_0???: begin
                    immed_count = 2'd1;
                    first_is_8bit = 1'b1;
                end
                8'b1011_1???: immed_count = 2'd1;
                8'hc6: begin
                    has_modrm = 1'b1;
                    immed_count = 2'd1;
                    first_is_8bit = 1'b1;
                end
                8'hc7: begin
                    has_modrm = 1'b1;
                    immed_count = 2'd1;
                end
                // only the test form of this group carries an immediate
                8'hf6: begin
                    has_modrm = 1'b1;
                    if (modrm_reg == 3'd0) begin
                        immed_count = 2'd1;
                        first_is_8bit = 1'b1;
                    end
                end
                8'hf7: begin
                    has_modrm = 1'b1;
                    if (modrm_reg == 3'd0)
                        immed_count = 2'd1;
                end
                8'he8, 8'he9: immed_count = 2'd1;
                8'heb, 8'hcd: begin
                    immed_count = 2'd1;
                    first_is_8bit = 1'b1;
                end
                // enter takes a frame size word and then a nesting level byte
                8'hc8: begin
                    immed_count = 2'd2;
                    second_is_8bit = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/immed_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module immed_reader (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic req_rd,
    input logic fifo_empty,
    input logic [7:0] fifo_rd_data,
    output logic fifo_rd_en,
    input logic immed_start,
    input logic immed_is_8bit,
    output logic immed_complete,
    output insn_decode_pkg::imm_word_t immediate
);

    // bytes still to pop for the current immediate
    logic [1:0] count;
    logic wide;
    logic pop;
    insn_decode_pkg::imm_word_t word;

    // the decoder only gets the read port while no immediate is in flight
    assign fifo_rd_en = (count == 2'd0) ? req_rd : !fifo_empty;
    assign pop = (count != 2'd0) && !fifo_empty;
    assign immed_complete = (count == 2'd1) && !fifo_empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= 2'd0;
            wide <= 1'b0;
        end else if (flush) begin
            count <= 2'd0;
            wide <= 1'b0;
        end else if (immed_start) begin
            count <= immed_is_8bit ? 2'd1 : 2'd2;
            wide <= !immed_is_8bit;
        end else if (pop) begin
            count <= count - 2'd1;
        end
    end

    // the first of two bytes is parked in the low half
    always_ff @(posedge clk) begin
        if (immed_start)
            word <= '0;
        else if (pop && count == 2'd2)
            word.bytes.lo <= fifo_rd_data;
    end

    // the last byte goes straight to the output so the word is valid on complete
    always_comb begin
        immediate = word;
        if (count == 2'd1) begin
            if (wide)
                immediate.bytes.hi = fifo_rd_data;
            else
                immediate.bytes.lo = fifo_rd_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic stall,
    input logic nearly_full,
    input logic fifo_empty,
    input logic [7:0] fifo_rd_data,
    output logic req_rd,
    output logic [7:0] table_opcode,
    output logic [2:0] table_reg,
    input logic has_modrm,
    input logic [1:0] immed_count,
    input logic first_is_8bit,
    input logic second_is_8bit,
    output logic immed_start,
    output logic immed_is_8bit,
    input logic immed_complete,
    input insn_decode_pkg::imm_word_t immediate,
    output insn_decode_pkg::instruction_t instruction,
    output logic complete
);

    typedef enum logic [2:0] {
        OPCODE,
        MODRM,
        DISPLACEMENT,
        IMMED1,
        IMMED2,
        WAIT_SPACE
    } state_t;

    state_t state;
    state_t next_state;
    insn_decode_pkg::instruction_t cur;
    insn_decode_pkg::instruction_t next_cur;
    logic finish;
    logic start_imm;
    logic start_8bit;
    logic hold;
    logic pending;
    logic load_new;
    logic release_held;
    logic [7:0] imm_len;

    function automatic logic has_displacement(input logic [7:0] m);
        has_displacement = (m[7:6] == 2'b00 && m[2:0] == 3'b110) || ^m[7:6];
    endfunction

    // the consumer still owns the output record
    assign hold = complete && stall;
    assign load_new = finish && !hold && !flush;
    assign release_held = pending && state == WAIT_SPACE && !stall && !flush;
    assign imm_len = immed_is_8bit ? 8'd1 : 8'd2;

    // table lookups use the live byte until the opcode and mod r/m are stored
    always_comb begin
        case (state)
            OPCODE: begin
                table_opcode = fifo_rd_data;
                table_reg = 3'd0;
            end
            MODRM: begin
                table_opcode = cur.opcode;
                table_reg = fifo_rd_data[5:3];
            end
            default: begin
                table_opcode = cur.opcode;
                table_reg = cur.mod_rm[5:3];
            end
        endcase
    end

    always_comb begin
        next_cur = cur;
        next_state = state;
        finish = 1'b0;
        start_imm = 1'b0;
        start_8bit = 1'b0;
        req_rd = 1'b0;

        case (state)
            OPCODE: begin
                if (!fifo_empty) begin
                    req_rd = 1'b1;
                    next_cur.length = cur.length + 8'd1;
                    casez (fifo_rd_data)
                        8'hf0: next_cur.lock = 1'b1;
                        8'hf2: next_cur.rep = insn_decode_pkg::REP_PREFIX_NE;
                        8'hf3: next_cur.rep = insn_decode_pkg::REP_PREFIX_E;
                        // bits 4:3 of the override prefix name the segment
                        8'b001?_?110: begin
                            next_cur.has_segment_override = 1'b1;
                            next_cur.segment = insn_decode_pkg::sr_t'(fifo_rd_data[4:3]);
                        end
                        default: begin
                            next_cur.opcode = fifo_rd_data;
                            next_cur.has_modrm = has_modrm;
                            if (has_modrm) begin
                                next_state = MODRM;
                            end else if (immed_count != 2'd0) begin
                                next_state = IMMED1;
                                start_imm = 1'b1;
                                start_8bit = first_is_8bit;
                            end else begin
                                finish = 1'b1;
                            end
                        end
                    endcase
                end
            end
            MODRM: begin
                if (!fifo_empty) begin
                    req_rd = 1'b1;
                    next_cur.length = cur.length + 8'd1;
                    next_cur.mod_rm = fifo_rd_data;
                    if (has_displacement(fifo_rd_data)) begin
                        next_state = DISPLACEMENT;
                        start_imm = 1'b1;
                        start_8bit = fifo_rd_data[7:6] == 2'b01;
                    end else if (immed_count != 2'd0) begin
                        next_state = IMMED1;
                        start_imm = 1'b1;
                        start_8bit = first_is_8bit;
                    end else begin
                        finish = 1'b1;
                    end
                end
            end
            DISPLACEMENT: begin
                if (immed_complete) begin
                    next_cur.displacement = immediate.value;
                    next_cur.length = cur.length + imm_len;
                    if (immed_count != 2'd0) begin
                        next_state = IMMED1;
                        start_imm = 1'b1;
                        start_8bit = first_is_8bit;
                    end else begin
                        finish = 1'b1;
                    end
                end
            end
            IMMED1: begin
                if (immed_complete) begin
                    next_cur.immediates[0].value = immediate.value;
                    next_cur.length = cur.length + imm_len;
                    if (immed_count == 2'd2) begin
                        next_state = IMMED2;
                        start_imm = 1'b1;
                        start_8bit = second_is_8bit;
                    end else begin
                        finish = 1'b1;
                    end
                end
            end
            IMMED2: begin
                if (immed_complete) begin
                    next_cur.immediates[1].value = immediate.value;
                    next_cur.length = cur.length + imm_len;
                    finish = 1'b1;
                end
            end
            WAIT_SPACE: begin
                if (!stall)
                    next_state = OPCODE;
            end
            default: next_state = OPCODE;
        endcase

        if (finish)
            next_state = (nearly_full || stall) ? WAIT_SPACE : OPCODE;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= OPCODE;
            complete <= 1'b0;
            immed_start <= 1'b0;
            immed_is_8bit <= 1'b0;
            pending <= 1'b0;
            cur <= '0;
        end else if (flush) begin
            state <= OPCODE;
            complete <= 1'b0;
            immed_start <= 1'b0;
            immed_is_8bit <= 1'b0;
            pending <= 1'b0;
            cur <= '0;
        end else begin
            state <= next_state;
            immed_start <= start_imm;
            if (start_imm)
                immed_is_8bit <= start_8bit;

            // the consumer takes the record on a cycle where stall is low
            if (complete && !stall)
                complete <= 1'b0;

            if (load_new) begin
                complete <= 1'b1;
                cur <= '0;
            end else if (finish) begin
                // finished while the output is held, so park it until stall drops
                pending <= 1'b1;
                cur <= next_cur;
            end else if (release_held) begin
                complete <= 1'b1;
                pending <= 1'b0;
                cur <= '0;
            end else begin
                cur <= next_cur;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_new)
            instruction <= next_cur;
        else if (release_held)
            instruction <= cur;
    end

endmodule

`default_nettype wire

/* rtl/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic stall,
    input logic nearly_full,
    input logic fetch_wr_en,
    input logic [7:0] fetch_byte,
    output logic fetch_full,
    output insn_decode_pkg::instruction_t instruction,
    output logic complete
);

    logic rd_en;
    logic [7:0] rd_data;
    logic empty;
    logic req_rd;
    logic [7:0] table_opcode;
    logic [2:0] table_reg;
    logic has_modrm;
    logic [1:0] immed_count;
    logic first_is_8bit;
    logic second_is_8bit;
    logic immed_start;
    logic immed_is_8bit;
    logic immed_complete;
    insn_decode_pkg::imm_word_t immediate;

    byte_fifo fifo_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .wr_en(fetch_wr_en),
        .wr_data(fetch_byte),
        .rd_en(rd_en),
        .rd_data(rd_data),
        .empty(empty),
        .full(fetch_full)
    );

    // the reader arbitrates the single queue read port
    immed_reader reader_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .req_rd(req_rd),
        .fifo_empty(empty),
        .fifo_rd_data(rd_data),
        .fifo_rd_en(rd_en),
        .immed_start(immed_start),
        .immed_is_8bit(immed_is_8bit),
        .immed_complete(immed_complete),
        .immediate(immediate)
    );

    opcode_table table_i (
        .opcode(table_opcode),
        .modrm_reg(table_reg),
        .has_modrm(has_modrm),
        .immed_count(immed_count),
        .first_is_8bit(first_is_8bit),
        .second_is_8bit(second_is_8bit)
    );

    insn_decoder decoder_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .stall(stall),
        .nearly_full(nearly_full),
        .fifo_empty(empty),
        .fifo_rd_data(rd_data),
        .req_rd(req_rd),
        .table_opcode(table_opcode),
        .table_reg(table_reg),
        .has_modrm(has_modrm),
        .immed_count(immed_count),
        .first_is_8bit(first_is_8bit),
        .second_is_8bit(second_is_8bit),
        .immed_start(immed_start),
        .immed_is_8bit(immed_is_8bit),
        .immed_complete(immed_complete),
        .immediate(immediate),
        .instruction(instruction),
        .complete(complete)
    );

endmodule

`default_nettype wire

/* verification/decode_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic stall,
    input logic rd_en,
    input logic empty,
    input logic immed_start,
    input logic immed_complete,
    input logic complete,
    input insn_decode_pkg::instruction_t instruction
);

    // set while the reader has an immediate in flight
    logic armed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            armed <= 1'b0;
        else if (flush)
            armed <= 1'b0;
        else if (immed_start)
            armed <= 1'b1;
        else if (immed_complete)
            armed <= 1'b0;
    end

    known_strobes: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(immed_start) && !$isunknown(complete))
        else $error("immed_start or complete is unknown");

    no_read_when_empty: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> !empty)
        else $error("queue read while empty");

    held_record_stable: assert property (@(posedge clk) disable iff (reset || flush)
        (complete && stall) |=> $stable(instruction))
        else $error("instruction changed while stalled");

    immed_after_start: assert property (@(posedge clk) disable iff (reset || flush)
        immed_complete |-> armed)
        else $error("immed_complete without a preceding immed_start");

endmodule

bind decode_top decode_checker checker_i (
    .clk(clk),
    .reset(reset),
    .flush(flush),
    .stall(stall),
    .rd_en(rd_en),
    .empty(empty),
    .immed_start(immed_start),
    .immed_complete(immed_complete),
    .complete(complete),
    .instruction(instruction)
);

`default_nettype wire

/* verification/decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic reset;
    logic flush;
    logic stall;
    logic nearly_full;
    logic fetch_wr_en;
    logic [7:0] fetch_byte;
    logic fetch_full;
    logic complete;
    insn_decode_pkg::instruction_t instruction;

    logic [7:0] byte_q[$];
    insn_decode_pkg::instruction_t exp_q[$];
    int cycles;
    int test_errors;
    int passed;
    int failed;

    decode_top dut_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .stall(stall),
        .nearly_full(nearly_full),
        .fetch_wr_en(fetch_wr_en),
        .fetch_byte(fetch_byte),
        .fetch_full(fetch_full),
        .instruction(instruction),
        .complete(complete)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // at most every other cycle, so a write seen as not full always lands
    always @(posedge clk) begin
        if (!reset && !fetch_wr_en && !fetch_full && byte_q.size() != 0 &&
            $urandom_range(0, 3) != 0) begin
            fetch_wr_en <= 1'b1;
            fetch_byte <= byte_q.pop_front();
        end else begin
            fetch_wr_en <= 1'b0;
        end
    end

    // a held record is compared again on every stalled cycle
    always @(posedge clk) begin
        if (!reset && complete) begin
            if (exp_q.size() == 0) begin
                $display("decoder produced a record that no test expected at %0t", $time);
                test_errors++;
            end else begin
                assert (instruction == exp_q[0])
                else begin
                    $display("[FAIL] %0t record %h, expected %h", $time, instruction, exp_q[0]);
                    test_errors++;
                end
                if (!stall)
                    void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d records outstanding", cycles,
                exp_q.size());
            $display("Something failed");
            $finish;
        end
    end

    task automatic push16(input logic [15:0] v);
        byte_q.push_back(v[7:0]);
        byte_q.push_back(v[15:8]);
    endtask

    // queues the bytes of one instruction and the record the decoder must build from them
    task automatic add_insn(input logic lock, input insn_decode_pkg::rep_prefix_t rep,
                            input logic seg_ovr, input insn_decode_pkg::sr_t seg,
                            input logic [7:0] opcode, input logic has_mrm,
                            input logic [7:0] mrm, input int n_imm, input logic w8_0,
                            input logic w8_1, input logic [15:0] disp,
                            input logic [15:0] imm0, input logic [15:0] imm1);
        insn_decode_pkg::instruction_t e;
        int start;
        int dwidth;
        start = byte_q.size();
        e = '0;
        dwidth = 0;
        if (lock)
            byte_q.push_back(8'hf0);
        if (seg_ovr)
            byte_q.push_back({3'b001, seg, 3'b110});
        if (rep == insn_decode_pkg::REP_PREFIX_E)
            byte_q.push_back(8'hf3);
        else if (rep == insn_decode_pkg::REP_PREFIX_NE)
            byte_q.push_back(8'hf2);
        byte_q.push_back(opcode);
        if (has_mrm) begin
            byte_q.push_back(mrm);
            if (mrm[7:6] == 2'b01)
                dwidth = 1;
            else if (mrm[7:6] == 2'b10 || (mrm[7:6] == 2'b00 && mrm[2:0] == 3'b110))
                dwidth = 2;
        end
        if (dwidth == 1) begin
            byte_q.push_back(disp[7:0]);
            e.displacement = {8'h00, disp[7:0]};
        end else if (dwidth == 2) begin
            push16(disp);
            e.displacement = disp;
        end
        if (n_imm > 0) begin
            if (w8_0)
                byte_q.push_back(imm0[7:0]);
            else
                push16(imm0);
            e.immediates[0].value = w8_0 ? {8'h00, imm0[7:0]} : imm0;
        end
        if (n_imm > 1) begin
            if (w8_1)
                byte_q.push_back(imm1[7:0]);
            else
                push16(imm1);
            e.immediates[1].value = w8_1 ? {8'h00, imm1[7:0]} : imm1;
        end
        e.opcode = opcode;
        e.has_modrm = has_mrm;
        e.mod_rm = has_mrm ? mrm : 8'h00;
        e.lock = lock;
        e.rep = rep;
        e.has_segment_override = seg_ovr;
        e.segment = seg_ovr ? seg : insn_decode_pkg::ES;
        e.length = 8'(byte_q.size() - start);
        exp_q.push_back(e);
    endtask

    task automatic add_plain(input logic [7:0] opcode, input logic has_mrm,
                             input logic [7:0] mrm, input int n_imm, input logic w8_0,
                             input logic w8_1, input logic [15:0] disp,
                             input logic [15:0] imm0, input logic [15:0] imm1);
        add_insn(1'b0, insn_decode_pkg::REP_PREFIX_NONE, 1'b0, insn_decode_pkg::ES,
            opcode, has_mrm, mrm, n_imm, w8_0, w8_1, disp, imm0, imm1);
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || byte_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        drain();
        if (test_errors == 0) begin
            $display("test %s passed", name);
            passed++;
        end else begin
            $display("test %s failed with %0d errors", name, test_errors);
            failed++;
        end
        test_errors = 0;
    endtask

    task automatic add_random();
        logic [7:0] m;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] d;
        m = 8'($urandom());
        a = 16'($urandom());
        b = 16'($urandom());
        d = 16'($urandom());
        case ($urandom_range(0, 5))
            0: add_plain(8'h40 + 8'($urandom_range(0, 7)), 0, 0, 0, 0, 0, 0, 0, 0);
            1: add_plain(8'hb0 + 8'($urandom_range(0, 7)), 0, 0, 1, 1, 0, 0, a, 0);
            2: add_plain(8'hb8 + 8'($urandom_range(0, 7)), 0, 0, 1, 0, 0, 0, a, 0);
            3: add_insn($urandom_range(0, 1) == 1, insn_decode_pkg::REP_PREFIX_NONE,
                   1'b1, insn_decode_pkg::sr_t'($urandom_range(0, 3)),
                   8'h81, 1, m, 1, 0, 0, d, a, 0);
            4: add_plain(8'h8b, 1, m, 0, 0, 0, d, 0, 0);
            default: add_plain(8'hc8, 0, 0, 2, 0, 1, 0, a, b);
        endcase
    endtask

    initial begin
        void'($urandom(32'h8ccd));
        reset = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        nearly_full = 1'b0;
        fetch_wr_en = 1'b0;
        fetch_byte = 8'h00;
        cycles = 0;
        test_errors = 0;
        passed = 0;
        failed = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        add_insn(1'b1, insn_decode_pkg::REP_PREFIX_E, 1'b1, insn_decode_pkg::CS,
            8'h90, 0, 0, 0, 0, 0, 0, 0, 0);
        finish_test("prefixes");

        add_plain(8'h8b, 1, 8'h46, 0, 0, 0, 16'h0010, 0, 0);
        add_plain(8'h8b, 1, 8'h86, 0, 0, 0, 16'h1234, 0, 0);
        add_plain(8'h8b, 1, 8'h06, 0, 0, 0, 16'h5678, 0, 0);
        finish_test("displacement");

        add_plain(8'hb8, 0, 0, 1, 0, 0, 0, 16'habcd, 0);
        add_plain(8'h81, 1, 8'hc3, 1, 0, 0, 0, 16'h1234, 0);
        add_plain(8'hc8, 0, 0, 2, 0, 1, 0, 16'h0100, 16'h0005);
        add_plain(8'hf7, 1, 8'h06, 1, 0, 0, 16'h0020, 16'heeff, 0);
        finish_test("immediates");

        @(posedge clk);
        stall <= 1'b1;
        nearly_full <= 1'b1;
        add_plain(8'hb8, 0, 0, 1, 0, 0, 0, 16'h4321, 0);
        add_plain(8'h80, 1, 8'h47, 1, 1, 0, 16'h0011, 16'h0022, 0);
        // more bytes wait behind the held record than the queue can take
        add_plain(8'hc8, 0, 0, 2, 0, 1, 0, 16'h0200, 16'h0003);
        add_plain(8'hf7, 1, 8'h86, 1, 0, 0, 16'h1111, 16'h2222, 0);
        add_plain(8'hb8, 0, 0, 1, 0, 0, 0, 16'h5555, 0);
        while (!complete)
            @(posedge clk);
        while (!fetch_full)
            @(posedge clk);
        repeat (4) @(posedge clk);
        stall <= 1'b0;
        nearly_full <= 1'b0;
        finish_test("stall");

        // a lock and segment prefix and half of an instruction, then flush
        byte_q.push_back(8'hf0);
        byte_q.push_back(8'h2e);
        byte_q.push_back(8'h81);
        byte_q.push_back(8'hc3);
        while (byte_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        add_plain(8'h90, 0, 0, 0, 0, 0, 0, 0, 0);
        add_plain(8'hb0, 0, 0, 1, 1, 0, 0, 16'h0077, 0);
        finish_test("flush");

        repeat (30) add_random();
        finish_test("random");

        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/insn_decode_pkg.sv
rtl/byte_fifo.sv
rtl/opcode_table.sv
rtl/immed_reader.sv
rtl/insn_decoder.sv
rtl/decode_top.sv
verification/decode_checker.sv
verification/decode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= decode_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -Wall -Wno-fatal

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | grep -q "Everything OK"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
